// ==== design/cf_pkg.sv ====
// sample and score types for the change scorer
// scorer tuning constants, fifo depth and counter width
package cf_pkg;

	// user value pulled from the trigger frame
	typedef logic [31:0] sample_t;

	// smoothed absolute deviation
	typedef logic [31:0] score_t;

	// mean correction is shifted right by this much
	// acts as the forgetting factor
	localparam int FORGET_SHIFT = 4;

	// smoothing window
	localparam int SMOOTH_LEN   = 4;
	localparam int SMOOTH_SHIFT = 2;

	localparam int FIFO_DEPTH = 16;

	// top bit is the sticky overflow flag
	localparam int CNT_W = 32;

endpackage

// ==== design/change_scorer.sv ====
// two-stage change scorer fed from the sample fifo
// stage one takes the absolute deviation from a forgetting running mean
// stage two averages the last four deviations
`timescale 1ns/1ps

module change_scorer
	import cf_pkg::*;
(
	input  logic    axis_aclk,
	input  logic    cf_rstn,
	input  logic    fifo_empty_i,
	input  sample_t fifo_data_i,
	output logic    fifo_rd_o,
	output score_t  score_o,
	output logic    score_valid_o
);

	// load doubles as the idle state
	typedef enum logic [1:0] {
		ST_LOAD,
		ST_DEVIATE,
		ST_SMOOTH
	} state_t;

	state_t                                state_q;
	sample_t                               sample_q;
	sample_t                               mean_q;
	logic signed [32:0]                    diff;
	logic signed [32:0]                    diff_abs;
	logic signed [32:0]                    mean_next;
	score_t                                dev_q;
	// previous deviations, newest first
	score_t                                hist_q [SMOOTH_LEN-1];
	logic [$bits(score_t)+SMOOTH_SHIFT-1:0] win_sum;

	// pop whenever waiting in load and something is queued
	assign fifo_rd_o = (state_q == ST_LOAD) & ~fifo_empty_i;

	assign diff      = signed'({1'b0, sample_q}) - signed'({1'b0, mean_q});
	assign diff_abs  = diff[32] ? -diff : diff;
	assign mean_next = signed'({1'b0, mean_q}) + (diff >>> FORGET_SHIFT);

	// window is the current deviation plus the history
	always_comb begin
		win_sum = {{SMOOTH_SHIFT{1'b0}}, dev_q};
		for (int i = 0; i < SMOOTH_LEN-1; i++) begin
			win_sum = win_sum + {{SMOOTH_SHIFT{1'b0}}, hist_q[i]};
		end
	end

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			state_q       <= ST_LOAD;
			mean_q        <= '0;
			score_valid_o <= 1'b0;
			for (int i = 0; i < SMOOTH_LEN-1; i++) begin
				hist_q[i] <= '0;
			end
		end else begin
			score_valid_o <= 1'b0;
			case (state_q)
				ST_LOAD: begin
					if (!fifo_empty_i)
						state_q <= ST_DEVIATE;
				end
				ST_DEVIATE: begin
					// truncation keeps the mean in sample range
					mean_q  <= mean_next[31:0];
					state_q <= ST_SMOOTH;
				end
				default: begin
					hist_q[0] <= dev_q;
					for (int i = 1; i < SMOOTH_LEN-1; i++) begin
						hist_q[i] <= hist_q[i-1];
					end
					score_valid_o <= 1'b1;
					state_q       <= ST_LOAD;
				end
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge axis_aclk) begin
		if (fifo_rd_o)
			sample_q <= fifo_data_i;
		if (state_q == ST_DEVIATE)
			dev_q <= diff_abs[31:0];
		if (state_q == ST_SMOOTH)
			score_o <= win_sum[$bits(score_t)+SMOOTH_SHIFT-1:SMOOTH_SHIFT];
	end

endmodule

// ==== design/pkt_fields_pkg.sv ====
// stream widths for the 256-bit frame path
// header field bit positions within beats 0 and 1
// trigger match constants and beat counter width
package pkt_fields_pkg;

	// axi-stream widths
	localparam int AXIS_DATA_W = 256;
	localparam int AXIS_KEEP_W = AXIS_DATA_W / 8;
	localparam int AXIS_USER_W = 128;

	// beat 0, ethernet and ipv4 headers
	localparam int ETH_TYPE_POS = 96;
	localparam int IP_PROTO_POS = 184;

	// beat 1, udp header and payload
	localparam int UDP_DST_PORT_POS = 32;
	localparam int USER_DATA_POS    = 80;
	localparam int USER_DATA_W      = 32;

	// ethertype shows up byte-swapped on the bus
	localparam logic [15:0] IP_TYPE       = 16'h0008;
	localparam logic [7:0]  UDP_PROTO     = 8'h11;
	localparam logic [15:0] UDP_PORT_TRIG = 16'd12345;

	// frames longer than the counter range just saturate
	localparam int BEAT_CNT_W = 8;

endpackage

// ==== design/sample_fifo.sv ====
// synchronous sample fifo
// circular buffer with occupancy count, full and empty flags
`timescale 1ns/1ps

module sample_fifo
	import cf_pkg::*;
#(
	parameter int DEPTH = FIFO_DEPTH
) (
	input  logic    axis_aclk,
	input  logic    cf_rstn,
	input  logic    wr_en_i,
	input  sample_t wr_data_i,
	input  logic    rd_en_i,
	output sample_t rd_data_o,
	output logic    empty_o,
	output logic    full_o
);

	sample_t                  mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(DEPTH)-1:0] rd_ptr_q;
	logic [$clog2(DEPTH):0]   count_q;
	logic                     do_wr;
	logic                     do_rd;

	assign empty_o = count_q == '0;
	assign full_o  = count_q == ($clog2(DEPTH)+1)'(DEPTH);

	// writes into a full queue and reads from an empty one are dropped
	assign do_wr = wr_en_i & ~full_o;
	assign do_rd = rd_en_i & ~empty_o;

	// head entry is always visible
	assign rd_data_o = mem[rd_ptr_q];

	always_ff @(posedge axis_aclk) begin
		if (do_wr) begin
			mem[wr_ptr_q] <= wr_data_i;
		end
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_wr)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_rd)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

// ==== design/stat_counters.sv ====
// frame and score statistics counters
// 31-bit wrapping count with sticky overflow in the top bit
`timescale 1ns/1ps

module stat_counters
	import cf_pkg::*;
(
	input  logic             axis_aclk,
	input  logic             cf_rstn,
	input  logic             frame_done_i,
	input  logic             score_done_i,
	input  logic             clear_counters_i,
	output logic [CNT_W-1:0] frame_count_o,
	output logic [CNT_W-1:0] score_count_o
);

	// next value of one counter, overflow sticks once set
	function automatic logic [CNT_W-1:0] bump(
		input logic [CNT_W-1:0] cnt,
		input logic             inc
	);
		logic [CNT_W-2:0] low;
		logic             wrap;
		low  = cnt[CNT_W-2:0] + (CNT_W-1)'(inc);
		wrap = inc & (&cnt[CNT_W-2:0]);
		return {cnt[CNT_W-1] | wrap, low};
	endfunction

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			frame_count_o <= '0;
			score_count_o <= '0;
		end else if (clear_counters_i) begin
			// clear beats a count landing in the same cycle
			frame_count_o <= '0;
			score_count_o <= '0;
		end else begin
			frame_count_o <= bump(frame_count_o, frame_done_i);
			score_count_o <= bump(score_count_o, score_done_i);
		end
	end

endmodule

// ==== design/udp_trigger_parser.sv ====
// frame parser for udp trigger frames
// checks ethertype and protocol on beat 0, port on beat 1
// emits one registered sample per matching frame
`timescale 1ns/1ps

module udp_trigger_parser
	import pkt_fields_pkg::*;
	import cf_pkg::*;
(
	input  logic                   axis_aclk,
	input  logic                   cf_rstn,
	input  logic [AXIS_DATA_W-1:0] tdata_i,
	input  logic                   tvalid_i,
	input  logic                   tready_i,
	input  logic                   tlast_i,
	output sample_t                sample_o,
	output logic                   sample_valid_o
);

	logic [BEAT_CNT_W-1:0] beat_cnt_q;
	logic                  ip_seen_q;
	logic                  udp_seen_q;
	logic                  xfer;
	logic                  ip_hit;
	logic                  udp_hit;
	logic                  port_hit;
	logic                  beat1;

	assign xfer     = tvalid_i & tready_i;
	assign beat1    = beat_cnt_q == BEAT_CNT_W'(1);
	assign ip_hit   = tdata_i[ETH_TYPE_POS +: 16] == IP_TYPE;
	assign udp_hit  = tdata_i[IP_PROTO_POS +: 8] == UDP_PROTO;
	assign port_hit = tdata_i[UDP_DST_PORT_POS +: 16] == UDP_PORT_TRIG;

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			beat_cnt_q     <= '0;
			ip_seen_q      <= 1'b0;
			udp_seen_q     <= 1'b0;
			sample_valid_o <= 1'b0;
		end else begin
			sample_valid_o <= 1'b0;
			if (xfer) begin
				// header flags only come from the first beat
				if (beat_cnt_q == '0) begin
					ip_seen_q  <= ip_hit;
					udp_seen_q <= udp_hit;
				end
				if (beat1 && ip_seen_q && udp_seen_q && port_hit) begin
					sample_valid_o <= 1'b1;
				end
				// end of frame wins over the flag capture above
				if (tlast_i) begin
					beat_cnt_q <= '0;
					ip_seen_q  <= 1'b0;
					udp_seen_q <= 1'b0;
				end else if (beat_cnt_q != '1) begin
					beat_cnt_q <= beat_cnt_q + 1'b1;
				end
			end
		end
	end

	// user value sits behind the udp header on beat 1
	always_ff @(posedge axis_aclk) begin
		if (xfer && beat1) begin
			sample_o <= tdata_i[USER_DATA_POS +: USER_DATA_W];
		end
	end

endmodule

// ==== design/wombat.sv ====
// top level of the stream monitor
// axi-stream pass-through with udp trigger parser,
// sample fifo, change scorer and statistics counters
`timescale 1ns/1ps

module wombat
	import pkt_fields_pkg::*;
	import cf_pkg::*;
(
	input  logic                   axis_aclk,
	input  logic                   cf_rstn,

	// slave stream
	input  logic [AXIS_DATA_W-1:0] s_axis_tdata_i,
	input  logic [AXIS_KEEP_W-1:0] s_axis_tkeep_i,
	input  logic [AXIS_USER_W-1:0] s_axis_tuser_i,
	input  logic                   s_axis_tvalid_i,
	input  logic                   s_axis_tlast_i,
	output logic                   s_axis_tready_o,

	// master stream
	output logic [AXIS_DATA_W-1:0] m_axis_tdata_o,
	output logic [AXIS_KEEP_W-1:0] m_axis_tkeep_o,
	output logic [AXIS_USER_W-1:0] m_axis_tuser_o,
	output logic                   m_axis_tvalid_o,
	output logic                   m_axis_tlast_o,
	input  logic                   m_axis_tready_i,

	input  logic                   clear_counters_i,
	output score_t                 score_o,
	output logic                   score_valid_o,
	output logic [CNT_W-1:0]       frame_count_o,
	output logic [CNT_W-1:0]       score_count_o
);

	sample_t sample;
	logic    sample_valid;
	sample_t fifo_head;
	logic    fifo_empty;
	logic    fifo_rd;
	logic    frame_done;

	// frames leave untouched
	assign m_axis_tdata_o  = s_axis_tdata_i;
	assign m_axis_tkeep_o  = s_axis_tkeep_i;
	assign m_axis_tuser_o  = s_axis_tuser_i;
	assign m_axis_tvalid_o = s_axis_tvalid_i;
	assign m_axis_tlast_o  = s_axis_tlast_i;
	assign s_axis_tready_o = m_axis_tready_i;

	assign frame_done = s_axis_tvalid_i & m_axis_tready_i & s_axis_tlast_i;

	udp_trigger_parser u_parser (
		.axis_aclk      (axis_aclk),
		.cf_rstn        (cf_rstn),
		.tdata_i        (s_axis_tdata_i),
		.tvalid_i       (s_axis_tvalid_i),
		.tready_i       (m_axis_tready_i),
		.tlast_i        (s_axis_tlast_i),
		.sample_o       (sample),
		.sample_valid_o (sample_valid)
	);

	sample_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_fifo (
		.axis_aclk (axis_aclk),
		.cf_rstn   (cf_rstn),
		.wr_en_i   (sample_valid),
		.wr_data_i (sample),
		.rd_en_i   (fifo_rd),
		.rd_data_o (fifo_head),
		.empty_o   (fifo_empty),
		.full_o    ()
	);

	change_scorer u_scorer (
		.axis_aclk     (axis_aclk),
		.cf_rstn       (cf_rstn),
		.fifo_empty_i  (fifo_empty),
		.fifo_data_i   (fifo_head),
		.fifo_rd_o     (fifo_rd),
		.score_o       (score_o),
		.score_valid_o (score_valid_o)
	);

	stat_counters u_stats (
		.axis_aclk        (axis_aclk),
		.cf_rstn          (cf_rstn),
		.frame_done_i     (frame_done),
		.score_done_i     (score_valid_o),
		.clear_counters_i (clear_counters_i),
		.frame_count_o    (frame_count_o),
		.score_count_o    (score_count_o)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the wombat testbench with verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module wombat_tb -Mdir obj_dir -f wombat.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/Vwombat_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "simulation failed with status $sim_status"
	exit $sim_status
fi

exit 0

// ==== test/wombat_tb.sv ====
// testbench for the wombat stream monitor
// random frames with stalls, score model queue, counter and clear checks
// pass-through monitor and a watchdog
`timescale 1ns/1ps

module wombat_tb
	import pkt_fields_pkg::*;
	import cf_pkg::*;
();

	localparam int NUM_FRAMES   = 600;
	localparam int TIMEOUT_NS   = NUM_FRAMES * 12 * 10 + 20000;
	localparam int DRAIN_CYCLES = 100;
	localparam int VW           = AXIS_DATA_W;

	logic                   axis_aclk;
	logic                   cf_rstn;
	logic [AXIS_DATA_W-1:0] s_axis_tdata_i;
	logic [AXIS_KEEP_W-1:0] s_axis_tkeep_i;
	logic [AXIS_USER_W-1:0] s_axis_tuser_i;
	logic                   s_axis_tvalid_i;
	logic                   s_axis_tlast_i;
	logic                   s_axis_tready_o;
	logic [AXIS_DATA_W-1:0] m_axis_tdata_o;
	logic [AXIS_KEEP_W-1:0] m_axis_tkeep_o;
	logic [AXIS_USER_W-1:0] m_axis_tuser_o;
	logic                   m_axis_tvalid_o;
	logic                   m_axis_tlast_o;
	logic                   m_axis_tready_i;
	logic                   clear_counters_i;
	score_t                 score_o;
	logic                   score_valid_o;
	logic [CNT_W-1:0]       frame_count_o;
	logic [CNT_W-1:0]       score_count_o;

	integer seed = 32'h1737afd1;

	// reference model state
	score_t mean_m = '0;
	score_t hist_m [SMOOTH_LEN-1] = '{default: '0};
	score_t model_q [$];
	score_t exp_score;
	int     expected_scores = 0;
	int     scores_seen     = 0;
	int     score_base      = 0;
	int     frames_done     = 0;

	wombat uut (.*);

	initial begin
		axis_aclk = 1'b0;
		forever #5 axis_aclk = ~axis_aclk;
	end

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_error(input string name, input logic [VW-1:0] expected,
			input logic [VW-1:0] actual);
		$display("FAIL %s expected %0h actual %0h", name, expected, actual);
		abort_run();
	endtask

	task automatic event_error(input string msg);
		$display("%s", msg);
		abort_run();
	endtask

	function automatic int pick_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [AXIS_DATA_W-1:0] random_word();
		logic [AXIS_DATA_W-1:0] w;
		for (int i = 0; i < AXIS_DATA_W / 32; i++)
			w[i*32 +: 32] = $random(seed);
		return w;
	endfunction

	// running mean with forgetting shift, then four-deviation average
	function automatic score_t predict_score(input sample_t sample);
		logic signed [33:0] diff;
		score_t             dev;
		logic [33:0]        sum;
		diff   = $signed({2'b00, sample}) - $signed({2'b00, mean_m});
		dev    = (diff < 0) ? 32'(-diff) : 32'(diff);
		mean_m = 32'($signed({2'b00, mean_m}) + (diff >>> FORGET_SHIFT));
		sum    = 34'(dev);
		for (int i = 0; i < SMOOTH_LEN-1; i++)
			sum = sum + 34'(hist_m[i]);
		for (int i = SMOOTH_LEN-2; i > 0; i--)
			hist_m[i] = hist_m[i-1];
		hist_m[0] = dev;
		return 32'(sum >> SMOOTH_SHIFT);
	endfunction

	// pass-through and score checks, sampled at the rising edge
	always @(posedge axis_aclk) begin
		assert (m_axis_tdata_o == s_axis_tdata_i)
			else value_error("m_axis_tdata_o", s_axis_tdata_i, m_axis_tdata_o);
		assert (m_axis_tkeep_o == s_axis_tkeep_i)
			else value_error("m_axis_tkeep_o", VW'(s_axis_tkeep_i), VW'(m_axis_tkeep_o));
		assert (m_axis_tuser_o == s_axis_tuser_i)
			else value_error("m_axis_tuser_o", VW'(s_axis_tuser_i), VW'(m_axis_tuser_o));
		assert (m_axis_tvalid_o == s_axis_tvalid_i)
			else value_error("m_axis_tvalid_o", VW'(s_axis_tvalid_i), VW'(m_axis_tvalid_o));
		assert (m_axis_tlast_o == s_axis_tlast_i)
			else value_error("m_axis_tlast_o", VW'(s_axis_tlast_i), VW'(m_axis_tlast_o));
		assert (s_axis_tready_o == m_axis_tready_i)
			else value_error("s_axis_tready_o", VW'(m_axis_tready_i), VW'(s_axis_tready_o));
		if (cf_rstn && score_valid_o) begin
			assert (model_q.size() != 0)
				else event_error("score_valid_o pulsed with no score expected");
			exp_score = model_q.pop_front();
			assert (score_o == exp_score)
				else value_error("score_o", VW'(exp_score), VW'(score_o));
			scores_seen++;
		end
	end

	task automatic drive_beat(input logic [AXIS_DATA_W-1:0] data, input logic last);
		logic taken;
		// idle gap, payload lines still toggle
		repeat (pick_below(3)) begin
			s_axis_tvalid_i = 1'b0;
			s_axis_tdata_i  = random_word();
			s_axis_tlast_i  = pick_below(2) == 1;
			m_axis_tready_i = pick_below(2) == 1;
			@(negedge axis_aclk);
		end
		s_axis_tvalid_i = 1'b1;
		s_axis_tdata_i  = data;
		s_axis_tkeep_i  = $random(seed);
		s_axis_tuser_i  = AXIS_USER_W'(random_word());
		s_axis_tlast_i  = last;
		taken = 1'b0;
		while (!taken) begin
			m_axis_tready_i = pick_below(4) != 0;
			taken = m_axis_tready_i;
			@(negedge axis_aclk);
		end
		s_axis_tvalid_i = 1'b0;
		if (last)
			frames_done++;
	endtask

	task automatic send_frame();
		int                     n_beats;
		logic                   ip_ok;
		logic                   proto_ok;
		logic                   port_ok;
		sample_t                user;
		logic [AXIS_DATA_W-1:0] beat [4];
		n_beats  = 1 + pick_below(4);
		ip_ok    = pick_below(5) != 0;
		proto_ok = pick_below(5) != 0;
		port_ok  = pick_below(2) != 0;
		user     = $random(seed);
		for (int b = 0; b < 4; b++)
			beat[b] = random_word();
		// near misses flip one bit of the field
		beat[0][ETH_TYPE_POS +: 16] = ip_ok ? IP_TYPE : IP_TYPE ^ (16'h0001 << pick_below(16));
		beat[0][IP_PROTO_POS +: 8]  = proto_ok ? UDP_PROTO : UDP_PROTO ^ (8'h01 << pick_below(8));
		beat[1][UDP_DST_PORT_POS +: 16] = port_ok ? UDP_PORT_TRIG :
			UDP_PORT_TRIG ^ (16'h0001 << pick_below(16));
		beat[1][USER_DATA_POS +: USER_DATA_W] = user;
		if (n_beats > 1 && ip_ok && proto_ok && port_ok) begin
			// keep the sample fifo from filling up
			while (expected_scores - scores_seen >= 12)
				@(negedge axis_aclk);
			model_q.push_back(predict_score(user));
			expected_scores++;
		end
		for (int b = 0; b < n_beats; b++)
			drive_beat(beat[b], b == n_beats - 1);
	endtask

	task automatic drain_and_check();
		for (int i = 0; i < DRAIN_CYCLES && scores_seen != expected_scores; i++)
			@(negedge axis_aclk);
		// a few more cycles to catch stray pulses
		repeat (8) @(negedge axis_aclk);
		assert (scores_seen == expected_scores)
			else value_error("score_valid_o pulses", VW'(expected_scores), VW'(scores_seen));
		assert (frame_count_o == CNT_W'(frames_done))
			else value_error("frame_count_o", VW'(frames_done), VW'(frame_count_o));
		assert (score_count_o == CNT_W'(scores_seen - score_base))
			else value_error("score_count_o", VW'(scores_seen - score_base), VW'(score_count_o));
	endtask

	task automatic clear_and_check();
		clear_counters_i = 1'b1;
		@(negedge axis_aclk);
		clear_counters_i = 1'b0;
		frames_done = 0;
		score_base  = scores_seen;
		assert (frame_count_o == '0)
			else value_error("frame_count_o", '0, VW'(frame_count_o));
		assert (score_count_o == '0)
			else value_error("score_count_o", '0, VW'(score_count_o));
	endtask

	initial begin
		cf_rstn          = 1'b0;
		s_axis_tdata_i   = '0;
		s_axis_tkeep_i   = '0;
		s_axis_tuser_i   = '0;
		s_axis_tvalid_i  = 1'b0;
		s_axis_tlast_i   = 1'b0;
		m_axis_tready_i  = 1'b0;
		clear_counters_i = 1'b0;
		repeat (4) @(negedge axis_aclk);
		cf_rstn = 1'b1;
		@(negedge axis_aclk);
		assert (score_valid_o == 1'b0)
			else value_error("score_valid_o", '0, VW'(score_valid_o));
		assert (frame_count_o == '0)
			else value_error("frame_count_o", '0, VW'(frame_count_o));
		assert (score_count_o == '0)
			else value_error("score_count_o", '0, VW'(score_count_o));

		for (int f = 0; f < NUM_FRAMES; f++) begin
			send_frame();
			if (f == NUM_FRAMES / 2 - 1) begin
				drain_and_check();
				clear_and_check();
			end
		end
		drain_and_check();

		assert (model_q.size() == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			event_error("expected scores were left in the model queue");
		end
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		event_error("timeout, the run did not finish in time");
	end

endmodule

// ==== wombat.f ====
design/pkt_fields_pkg.sv
design/cf_pkg.sv
design/udp_trigger_parser.sv
design/sample_fifo.sv
design/change_scorer.sv
design/stat_counters.sv
design/wombat.sv
test/wombat_tb.sv
